/* src/fifo_pkg.sv */
// --------------------------------------------------------------------
// Shared sizes and storage port types for the synchronous FIFO
// Depth and width are fixed here and every module uses them directly
// Depth must be at least 2 so the address counters have real width
// --------------------------------------------------------------------

package fifo_pkg;

  // --------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------

  // Number of storage entries
  localparam int FIFO_DEPTH = 8;

  // Item width in bits
  localparam int DATA_WIDTH = 16;

  // Storage address, wide enough for FIFO_DEPTH entries
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // Counts run from 0 up to FIFO_DEPTH inclusive
  localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  // --------------------------------------------------------------------
  // Storage port types
  // --------------------------------------------------------------------

  // Write port, driven by the push controller
  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
  } ram_wr_t;

  // Read request, driven by the pop controller
  // Data comes back as a plain word in the same cycle
  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
  } ram_rd_t;

endpackage : fifo_pkg

/* src/fifo_push_ctrl.sv */
// --------------------------------------------------------------------
// Push side of the FIFO with ready/valid flow control
// Bypass data is the raw push input and may change while not accepted
// Slot count and full flag update one edge after ram_push or ram_pop
// --------------------------------------------------------------------
`timescale 1ns/1ps

module fifo_push_ctrl import fifo_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,

  // Producer side
  input  logic                   push_valid,
  input  logic [DATA_WIDTH-1:0]  push_data,
  output logic                   push_ready,

  // Bypass offer to the pop side
  input  logic                   bypass_ready,
  output logic                   bypass_valid,
  output logic [DATA_WIDTH-1:0]  bypass_data,

  // Storage write port
  output ram_wr_t                ram_wr,

  // Strobes between the controllers
  output logic                   ram_push,
  input  logic                   ram_pop,

  // Status
  output logic                   full,
  output logic [COUNT_WIDTH-1:0] slots
);

  // --------------------------------------------------------------------
  // Flow control
  // --------------------------------------------------------------------

  logic                   push;
  logic [ADDR_WIDTH-1:0]  wr_addr;
  logic [COUNT_WIDTH-1:0] slots_next;

  // Full flag is registered, so ready never depends on push_valid
  assign push_ready = !full;
  assign push       = push_valid && push_ready;

  // Offer every push to the pop side
  assign bypass_valid = push_valid;
  assign bypass_data  = push_data;

  // Only items the pop side did not take go into storage
  assign ram_push = push && !bypass_ready;

  // Storage write
  assign ram_wr.valid = ram_push;
  assign ram_wr.addr  = wr_addr;
  assign ram_wr.data  = push_data;

  // --------------------------------------------------------------------
  // Write address
  // --------------------------------------------------------------------

  // Wraps after the last entry
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_addr <= '0;
    end else if (ram_push) begin
      if (wr_addr == ADDR_WIDTH'(FIFO_DEPTH - 1)) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------
  // Free-slot count
  // --------------------------------------------------------------------

  always_comb begin
    slots_next = slots;
    // Push and pop together leave the count alone
    if (ram_push && !ram_pop) begin
      slots_next = slots - 1'b1;
    end else if (!ram_push && ram_pop) begin
      slots_next = slots + 1'b1;
    end
  end

  // Empty buffer on reset, every slot free
  always_ff @(posedge clk) begin
    if (reset) begin
      slots <= COUNT_WIDTH'(FIFO_DEPTH);
      full  <= 1'b0;
    end else if (ram_push || ram_pop) begin
      slots <= slots_next;
      full  <= (slots_next == '0);
    end
  end

endmodule : fifo_push_ctrl

/* src/fifo_pop_ctrl.sv */
// --------------------------------------------------------------------
// Pop side of the FIFO with ready/valid flow control
// While storage is empty the bypass item is shown on pop_data
// Storage read is combinational, so data is valid in the same cycle
// Item count and empty flag update one edge after ram_push or ram_pop
// --------------------------------------------------------------------
`timescale 1ns/1ps

module fifo_pop_ctrl import fifo_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,

  // Consumer side
  input  logic                   pop_ready,
  output logic                   pop_valid,
  output logic [DATA_WIDTH-1:0]  pop_data,

  // Bypass offer from the push side
  input  logic                   bypass_valid,
  input  logic [DATA_WIDTH-1:0]  bypass_data,
  output logic                   bypass_ready,

  // Storage read port
  output ram_rd_t                ram_rd,
  input  logic [DATA_WIDTH-1:0]  rd_data,

  // Strobes between the controllers
  input  logic                   ram_push,
  output logic                   ram_pop,

  // Status
  output logic                   empty,
  output logic [COUNT_WIDTH-1:0] items
);

  // --------------------------------------------------------------------
  // Flow control
  // --------------------------------------------------------------------

  logic                   pop;
  logic [ADDR_WIDTH-1:0]  rd_addr;
  logic [COUNT_WIDTH-1:0] items_next;

  // Stored items first, otherwise whatever is being pushed right now
  assign pop_valid = !empty || bypass_valid;
  assign pop_data  = empty ? bypass_data : rd_data;
  assign pop       = pop_valid && pop_ready;

  // Take the push directly only when nothing is waiting in storage
  assign bypass_ready = empty && pop_ready;

  // A bypassed pop never touches storage
  assign ram_pop = pop && !empty;

  // Head of the queue is always being read while storage holds items
  assign ram_rd.valid = !empty;
  assign ram_rd.addr  = rd_addr;

  // --------------------------------------------------------------------
  // Read address
  // --------------------------------------------------------------------

  // Follows the write address around the same ring
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_addr <= '0;
    end else if (ram_pop) begin
      if (rd_addr == ADDR_WIDTH'(FIFO_DEPTH - 1)) begin
        rd_addr <= '0;
      end else begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------
  // Stored-item count
  // --------------------------------------------------------------------

  always_comb begin
    items_next = items;
    // Simultaneous push and pop cancel out
    if (ram_push && !ram_pop) begin
      items_next = items + 1'b1;
    end else if (!ram_push && ram_pop) begin
      items_next = items - 1'b1;
    end
  end

  // Nothing stored after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      items <= '0;
      empty <= 1'b1;
    end else if (ram_push || ram_pop) begin
      items <= items_next;
      empty <= (items_next == '0);
    end
  end

endmodule : fifo_pop_ctrl

/* src/fifo_ram.sv */
// --------------------------------------------------------------------
// FIFO storage array, one write port and one read port
// Writes land at the clock edge, reads are combinational
// Contents are not reset and hold garbage until written
// --------------------------------------------------------------------
`timescale 1ns/1ps

module fifo_ram import fifo_pkg::*; (
  input  logic                  clk,

  // Write port from the push controller
  input  ram_wr_t               ram_wr,

  // Read port from the pop controller
  input  ram_rd_t               ram_rd,
  output logic [DATA_WIDTH-1:0] rd_data
);

  // --------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  // Registered write
  always_ff @(posedge clk) begin
    if (ram_wr.valid) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // --------------------------------------------------------------------
  // Read
  // --------------------------------------------------------------------

  // Idle read port returns zero instead of stale entries
  always_comb begin
    if (ram_rd.valid) begin
      rd_data = mem[ram_rd.addr];
    end else begin
      rd_data = '0;
    end
  end

endmodule : fifo_ram

/* src/fifo_top.sv */
// --------------------------------------------------------------------
// Synchronous FIFO top level, single clock domain
// Ready/valid on both sides, zero-latency bypass when empty
// push_ready comes from a register, pop_valid may follow push_valid
// --------------------------------------------------------------------
`timescale 1ns/1ps

module fifo_top import fifo_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,

  // Producer side
  input  logic                   push_valid,
  input  logic [DATA_WIDTH-1:0]  push_data,
  output logic                   push_ready,

  // Consumer side
  output logic                   pop_valid,
  output logic [DATA_WIDTH-1:0]  pop_data,
  input  logic                   pop_ready,

  // Status
  output logic                   full,
  output logic                   empty,
  output logic [COUNT_WIDTH-1:0] slots,
  output logic [COUNT_WIDTH-1:0] items
);

  // --------------------------------------------------------------------
  // Internal wiring
  // --------------------------------------------------------------------

  // Storage ports
  ram_wr_t               ram_wr;
  ram_rd_t               ram_rd;
  logic [DATA_WIDTH-1:0] rd_data;

  // Controller strobes
  logic                  ram_push;
  logic                  ram_pop;

  // Bypass handshake
  logic                  bypass_valid;
  logic [DATA_WIDTH-1:0] bypass_data;
  logic                  bypass_ready;

  // --------------------------------------------------------------------
  // Instances
  // --------------------------------------------------------------------

  fifo_push_ctrl u_push_ctrl (
    .clk          (clk),
    .reset        (reset),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .push_ready   (push_ready),
    .bypass_ready (bypass_ready),
    .bypass_valid (bypass_valid),
    .bypass_data  (bypass_data),
    .ram_wr       (ram_wr),
    .ram_push     (ram_push),
    .ram_pop      (ram_pop),
    .full         (full),
    .slots        (slots)
  );

  fifo_pop_ctrl u_pop_ctrl (
    .clk          (clk),
    .reset        (reset),
    .pop_ready    (pop_ready),
    .pop_valid    (pop_valid),
    .pop_data     (pop_data),
    .bypass_valid (bypass_valid),
    .bypass_data  (bypass_data),
    .bypass_ready (bypass_ready),
    .ram_rd       (ram_rd),
    .rd_data      (rd_data),
    .ram_push     (ram_push),
    .ram_pop      (ram_pop),
    .empty        (empty),
    .items        (items)
  );

  fifo_ram u_ram (
    .clk     (clk),
    .ram_wr  (ram_wr),
    .ram_rd  (ram_rd),
    .rd_data (rd_data)
  );

endmodule : fifo_top

/* test/fifo_assertions.sv */
// --------------------------------------------------------------------
// Flow-control and count properties of the FIFO top level
// Bound into every fifo_top instance and checked at the rising edge
// Properties are off while reset is high
// Every failed property is also tallied in failures
// --------------------------------------------------------------------
`timescale 1ns/1ps

module fifo_assertions import fifo_pkg::*; (
  input logic                   clk,
  input logic                   reset,
  input logic                   push_valid,
  input logic                   push_ready,
  input logic                   pop_valid,
  input logic [COUNT_WIDTH-1:0] slots,
  input logic [COUNT_WIDTH-1:0] items
);

  // Property violations so far
  int failures = 0;

  // Producer held off once storage holds FIFO_DEPTH items
  full_blocks_push: assert property (@(posedge clk) disable iff (reset)
    (items == COUNT_WIDTH'(FIFO_DEPTH)) |-> !push_ready)
    else begin
      $error("push_ready high while the FIFO is full");
      failures++;
    end

  // Both controllers agree on occupancy
  counts_add_up: assert property (@(posedge clk) disable iff (reset)
    (int'(slots) + int'(items)) == FIFO_DEPTH)
    else begin
      $error("slots plus items differ from the depth");
      failures++;
    end

  // Nothing to offer when nothing is stored and nothing is pushed
  no_phantom_pop: assert property (@(posedge clk) disable iff (reset)
    (items == '0 && !push_valid) |-> !pop_valid)
    else begin
      $error("pop_valid high with nothing stored and nothing pushed");
      failures++;
    end

endmodule : fifo_assertions

bind fifo_top fifo_assertions u_assertions (
  .clk        (clk),
  .reset      (reset),
  .push_valid (push_valid),
  .push_ready (push_ready),
  .pop_valid  (pop_valid),
  .slots      (slots),
  .items      (items)
);

/* test/fifo_tb.sv */
// --------------------------------------------------------------------
// Testbench for the synchronous FIFO
// Phases and the expected pop order come from the golden file,
// whose path is relative to the project root
// Inputs change on the falling edge, outputs are sampled 1 ns later
// --------------------------------------------------------------------
`timescale 1ns/1ps

module fifo_tb import fifo_pkg::*; ();

  // --------------------------------------------------------------------
  // DUT, clock and run state
  // --------------------------------------------------------------------

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   push_valid;
  logic [DATA_WIDTH-1:0]  push_data;
  logic                   push_ready;
  logic                   pop_valid;
  logic [DATA_WIDTH-1:0]  pop_data;
  logic                   pop_ready;
  logic                   full;
  logic                   empty;
  logic [COUNT_WIDTH-1:0] slots;
  logic [COUNT_WIDTH-1:0] items;

  // 100 ns period
  always #50 clk = ~clk;

  fifo_top DUT (.*);

  // Phase count, three words per phase, item count, then the items
  logic [31:0]           golden [64];
  // Queue model of the items that sit in storage
  logic [DATA_WIDTH-1:0] model_q [$];
  logic [DATA_WIDTH-1:0] next_data;
  logic [31:0]           lfsr;
  logic                  seen_push_ready;
  logic                  aborted;
  int                    phases;
  int                    total_items;
  int                    first_item;
  int                    pushed;
  int                    popped;
  int                    errors;
  int                    tests_run;
  int                    tests_failed;
  int                    wait_limit = 200;

  // --------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------

  function automatic logic [31:0] golden_word(input int index);
    return golden[index[5:0]];
  endfunction

  // Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // Eight fresh bits against a chance out of 0x100
  task automatic draw_chance(input logic [31:0] chance, output logic hit);
    logic [7:0] value;
    value = '0;
    repeat (8) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[6:0], lfsr[0]};
    end
    hit = ({24'd0, value} < chance);
  endtask

  task automatic value_mismatch(input string what, input int got, input int expected);
    $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
    errors++;
  endtask

  // Registered status against the model after the last edge
  task automatic check_status();
    int size;
    size = model_q.size();
    assert (int'(items) == size) else value_mismatch("items", int'(items), size);
    assert (int'(slots) == FIFO_DEPTH - size)
      else value_mismatch("slots", int'(slots), FIFO_DEPTH - size);
    assert (empty == (size == 0)) else value_mismatch("empty", int'(empty), int'(size == 0));
    assert (full == (size == FIFO_DEPTH))
      else value_mismatch("full", int'(full), int'(size == FIFO_DEPTH));
  endtask

  // Drives, samples and updates the model for one clock cycle
  task automatic step(input logic want_push, input logic want_pop,
                      output logic push_fire, output logic pop_fire);
    int          size;
    logic        exp_push_ready;
    logic        exp_pop_valid;
    logic [31:0] word;
    @(negedge clk);
    check_status();
    size = model_q.size();
    // No pushes beyond the golden sequence
    push_valid     = want_push && (pushed < total_items);
    push_data      = next_data;
    pop_ready      = want_pop;
    exp_push_ready = (size < FIFO_DEPTH);
    exp_pop_valid  = (size != 0) || push_valid;
    #1;
    seen_push_ready = push_ready;
    assert (push_ready == exp_push_ready)
      else value_mismatch("push_ready", int'(push_ready), int'(exp_push_ready));
    assert (pop_valid == exp_pop_valid)
      else value_mismatch("pop_valid", int'(pop_valid), int'(exp_pop_valid));
    push_fire = push_valid && exp_push_ready;
    pop_fire  = exp_pop_valid && pop_ready;
    if (pop_fire) begin
      if (popped < total_items) begin
        word = golden_word(first_item + popped);
        assert (pop_data == word[DATA_WIDTH-1:0])
          else value_mismatch("pop_data", int'(pop_data), int'(word[DATA_WIDTH-1:0]));
      end else begin
        $display("error at %0t ns: item %0h popped after the whole sequence", $time, pop_data);
        errors++;
      end
    end
    // A bypassed item goes in and straight back out
    if (push_fire) begin
      model_q.push_back(push_data);
      next_data = next_data + 1'b1;
      pushed++;
    end
    if (pop_fire) begin
      void'(model_q.pop_front());
      popped++;
    end
    @(posedge clk);
  endtask

  task automatic close_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  // --------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------

  task automatic load_golden();
    logic [31:0] word;
    for (int i = 0; i < 64; i++) begin
      golden[i] = 32'(i);
    end
    $readmemh("test/fifo_golden.txt", golden);
    phases      = int'(golden_word(0));
    total_items = int'(golden_word(3 * phases + 1));
    first_item  = 3 * phases + 2;
    if (phases == 0 || phases > 16 || total_items == 0 || first_item + total_items > 64) begin
      $display("golden file is missing or malformed");
      errors++;
      aborted = 1'b1;
    end else begin
      // Push data counts up from the first expected item
      word      = golden_word(first_item);
      next_data = word[DATA_WIDTH-1:0];
    end
  endtask

  task automatic check_reset();
    reset = 1'b1;
    repeat (10) begin
      @(posedge clk);
    end
    @(negedge clk);
    reset = 1'b0;
    #1;
    assert (push_ready == 1'b1) else value_mismatch("push_ready", int'(push_ready), 1);
    assert (pop_valid == 1'b0) else value_mismatch("pop_valid", int'(pop_valid), 0);
    assert (empty == 1'b1) else value_mismatch("empty", int'(empty), 1);
    assert (full == 1'b0) else value_mismatch("full", int'(full), 0);
    assert (int'(slots) == FIFO_DEPTH) else value_mismatch("slots", int'(slots), FIFO_DEPTH);
    assert (int'(items) == 0) else value_mismatch("items", int'(items), 0);
  endtask

  task automatic check_bypass();
    logic push_fire;
    logic pop_fire;
    // Consumer always ready so each push leaves in its own cycle
    repeat (4) begin
      step(1'b1, 1'b1, push_fire, pop_fire);
      #1;
      // Storage untouched by the edge that took the item
      assert (int'(items) == 0) else value_mismatch("items after bypass", int'(items), 0);
    end
    // Idle cycle so the count check sees the last edge
    step(1'b0, 1'b1, push_fire, pop_fire);
  endtask

  task automatic check_backpressure();
    logic push_fire;
    logic pop_fire;
    int   accepted;
    int   cycles;
    accepted        = 0;
    cycles          = 0;
    seen_push_ready = 1'b1;
    // Consumer stalled while pushing until the FIFO refuses
    while (seen_push_ready) begin
      if (cycles == wait_limit) begin
        $display("timeout: push_ready still high after %0d cycles of back-pressure", cycles);
        errors++;
        aborted = 1'b1;
        return;
      end
      step(1'b1, 1'b0, push_fire, pop_fire);
      accepted += int'(push_valid && seen_push_ready);
      cycles++;
    end
    assert (accepted == FIFO_DEPTH) else value_mismatch("accepted items", accepted, FIFO_DEPTH);
    // One pop while full brings push_ready back a cycle later
    step(1'b0, 1'b1, push_fire, pop_fire);
    step(1'b0, 1'b0, push_fire, pop_fire);
    assert (seen_push_ready) else begin
      $display("error at %0t ns: push_ready did not return after one pop", $time);
      errors++;
    end
  endtask

  task automatic check_random_order();
    logic want_push;
    logic want_pop;
    logic push_fire;
    logic pop_fire;
    int   base;
    int   cycles;
    for (int p = 0; p < phases; p++) begin
      base = 1 + 3 * p;
      for (int c = 0; c < int'(golden_word(base)); c++) begin
        draw_chance(golden_word(base + 1), want_push);
        draw_chance(golden_word(base + 2), want_pop);
        step(want_push, want_pop, push_fire, pop_fire);
      end
    end
    // Push what is left, then drain
    cycles = 0;
    while (popped < total_items) begin
      if (cycles == wait_limit) begin
        $display("timeout: only %0d of %0d items popped while draining", popped, total_items);
        errors++;
        aborted = 1'b1;
        return;
      end
      step(1'b1, 1'b1, push_fire, pop_fire);
      cycles++;
    end
    assert (pushed == total_items) else value_mismatch("pushed items", pushed, total_items);
    step(1'b0, 1'b0, push_fire, pop_fire);
  endtask

  // --------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------

  initial begin
    int start;
    int prop_failures;
    reset           = 1'b1;
    push_valid      = 1'b0;
    push_data       = '0;
    pop_ready       = 1'b0;
    next_data       = '0;
    lfsr            = 32'h2b9326ec;
    seen_push_ready = 1'b0;
    aborted         = 1'b0;
    errors          = 0;
    pushed          = 0;
    popped          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    load_golden();
    if (!aborted) begin
      start = errors;
      check_reset();
      close_test("reset", start);
    end
    if (!aborted) begin
      start = errors;
      check_bypass();
      close_test("bypass", start);
    end
    if (!aborted) begin
      start = errors;
      check_backpressure();
      close_test("back-pressure", start);
    end
    if (!aborted) begin
      start = errors;
      check_random_order();
      close_test("random order", start);
    end
    // Settle the last edge before reading the bound checker
    @(negedge clk);
    prop_failures = DUT.u_assertions.failures;
    errors += prop_failures;
    $display("tests run %0d, failed %0d, errors %0d, property failures %0d",
             tests_run, tests_failed, errors, prop_failures);
    $display("items popped %0d of %0d", popped, total_items);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : fifo_tb

/* test/fifo_golden.txt */
// Phases: count, then per line cycles, push-valid chance, pop-ready chance (hex, out of 100)
// Items: count, then the expected pop order; push data counts up from the first item
4
10 c0 40
18 40 c0
0c 100 00
20 80 80
// Expected pop sequence
1c
a5c0 a5c1 a5c2 a5c3
a5c4 a5c5 a5c6 a5c7
a5c8 a5c9 a5ca a5cb
a5cc a5cd a5ce a5cf
a5d0 a5d1 a5d2 a5d3
a5d4 a5d5 a5d6 a5d7
a5d8 a5d9 a5da a5db

/* list.f */
src/fifo_pkg.sv
src/fifo_push_ctrl.sv
src/fifo_pop_ctrl.sv
src/fifo_ram.sv
src/fifo_top.sv
test/fifo_assertions.sv
test/fifo_tb.sv

/* Makefile */
# Verilator build and run of the FIFO testbench
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR   ?= verilator
TOP         ?= fifo_tb
FILE_LIST   ?= list.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 100
VFLAGS      ?= --binary --assert --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; \
	elif ! grep -q "TEST OK" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
